/* src/cart_pkg.sv */
// Cartridge constants: ROM address type, store depth, header size, download indices, latencies
package cart_pkg;

	// ========================================================================
	// ROM store geometry
	// ========================================================================
	localparam int ROM_ADDR_W = 12;               // 4 KiB store
	localparam int ROM_DEPTH  = 1 << ROM_ADDR_W;

	typedef logic [ROM_ADDR_W-1:0] rom_addr_t;    // Byte address into the store

	// Optional copier header in front of the image
	localparam int HEADER_BYTES = 512;

	// ========================================================================
	// Download indices
	// ========================================================================
	localparam logic [7:0] CODE_INDEX = 8'hff;    // Cheat records
	localparam logic [4:0] GG_INDEX   = 5'd2;     // Low index bits of a Game Gear image

	// ========================================================================
	// Timing
	// ========================================================================
	localparam int WRITE_LATENCY = 3;             // Request toggle to acknowledge toggle
	localparam int CE_PERIOD     = 30;            // Clock enable sequence length

endpackage

/* src/cheat_pkg.sv */
// Cheat record constants: record length, field width, byte grouping and field numbers
package cheat_pkg;

	// ========================================================================
	// Record layout
	// ========================================================================
	localparam int CODE_BYTES  = 16;                  // One record per code
	localparam int CODE_BYTE_W = $clog2(CODE_BYTES);  // Byte number within a record

	// Each field is four bytes, least significant first
	localparam int CODE_FIELD_W = 32;
	localparam int FIELD_BYTES  = CODE_FIELD_W / 8;

	typedef logic [CODE_FIELD_W-1:0] code_field_t;

	// ========================================================================
	// Field numbers, byte group = field number * FIELD_BYTES
	// ========================================================================
	localparam int FIELD_FLAGS   = 0;   // Bytes 0 to 3
	localparam int FIELD_ADDR    = 1;   // Bytes 4 to 7
	localparam int FIELD_COMPARE = 2;   // Bytes 8 to 11
	localparam int FIELD_REPLACE = 3;   // Bytes 12 to 15

endpackage

/* src/clock_enable_gen.sv */
// Clock enable sequencer for CPU, VDP, pixel and sound sample enables
`timescale 1ns/1ps

module clock_enable_gen (
	input  logic clk_sys,
	input  logic reset,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);
	import cart_pkg::*;

	logic [$clog2(CE_PERIOD)-1:0] cnt;

	// ========================================================================
	// Step counter and registered enables
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cnt    <= '0;
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_sp  <= 1'b0;
		end else begin
			if (int'(cnt) == CE_PERIOD - 1)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;

			ce_sp  <= cnt[0];   // Half rate
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;

			// VDP every 5, pixel every 10, CPU every 15
			case (int'(cnt))
				4, 14: ce_vdp <= 1'b1;
				9: begin
					ce_cpu <= 1'b1;
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
				end
				19, 29: begin
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
				end
				24: begin
					ce_cpu <= 1'b1;   // CPU phase kept off the pixel slot
					ce_vdp <= 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

/* src/rom_loader.sv */
// Cartridge download pacing, toggle write requests, mirror masks and header detect
`timescale 1ns/1ps

module rom_loader (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                cart_active,
	input  logic                dl_wr,
	input  logic [7:0]          dl_index,
	input  logic [7:0]          dl_data,
	output logic                dl_wait,
	output cart_pkg::rom_addr_t wr_addr,
	output logic [7:0]          wr_data,
	output logic                wr_req,
	input  logic                wr_ack,
	output cart_pkg::rom_addr_t cart_mask,
	output cart_pkg::rom_addr_t header_mask,
	output logic                has_header,
	output logic                game_gear
);
	import cart_pkg::*;

	rom_addr_t byte_cnt;     // Completed writes
	rom_addr_t cur_addr;
	rom_addr_t byte_total;
	logic      active_d;
	logic      cart_start;
	logic      cart_end;
	logic      accept;
	logic      done;

	assign cart_start = cart_active & ~active_d;
	assign cart_end   = ~cart_active & active_d;
	assign accept     = dl_wr & cart_active & ~dl_wait;
	assign done       = dl_wait & (wr_req == wr_ack);   // Store has caught up

	// First byte may arrive in the same cycle the download opens
	assign cur_addr   = cart_start ? '0 : byte_cnt;
	assign byte_total = dl_wait ? byte_cnt + 1'b1 : byte_cnt;

	// ========================================================================
	// Handshake, counter and learned cartridge properties
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_d    <= 1'b0;
			dl_wait     <= 1'b0;
			wr_req      <= 1'b0;
			byte_cnt    <= '0;
			cart_mask   <= '0;
			header_mask <= '0;
			has_header  <= 1'b0;
			game_gear   <= 1'b0;
		end else begin
			active_d <= cart_active;

			if (cart_start)
				byte_cnt <= '0;
			else if (done)
				byte_cnt <= byte_cnt + 1'b1;

			if (accept) begin
				dl_wait <= 1'b1;
				wr_req  <= ~wr_req;   // One toggle per byte
				cart_mask <= (cur_addr == '0) ? '0 : cart_mask | cur_addr;
				header_mask <= (cur_addr == rom_addr_t'(HEADER_BYTES)) ? '0 :
					header_mask | (cur_addr - rom_addr_t'(HEADER_BYTES));
				game_gear <= dl_index[4:0] == GG_INDEX;
			end else if (done) begin
				dl_wait <= 1'b0;
			end

			// Odd multiple of 512 bytes means a copier header
			if (cart_end)
				has_header <= byte_total[$clog2(HEADER_BYTES)];
		end
	end

	// Address and data held until the acknowledge
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			wr_addr <= cur_addr;
			wr_data <= dl_data;
		end
	end

endmodule

/* src/rom_store.sv */
// ROM byte store with delayed toggle acknowledge and masked, header offset read port
`timescale 1ns/1ps

module rom_store (
	input  logic                clk_sys,
	input  logic                reset,
	input  cart_pkg::rom_addr_t wr_addr,
	input  logic [7:0]          wr_data,
	input  logic                wr_req,
	output logic                wr_ack,
	input  cart_pkg::rom_addr_t cart_mask,
	input  cart_pkg::rom_addr_t header_mask,
	input  logic                has_header,
	input  logic                rd,
	input  cart_pkg::rom_addr_t rd_addr,
	output logic [7:0]          rd_data,
	output logic                rd_valid
);
	import cart_pkg::*;

	logic [7:0]               mem [ROM_DEPTH];
	logic [WRITE_LATENCY-1:0] ack_pipe;      // Request toggle delay line
	logic                     wr_strobe;
	rom_addr_t                rd_phys;

	// ========================================================================
	// Write side
	// ========================================================================
	assign wr_strobe = wr_req ^ ack_pipe[0];   // Single cycle per toggle
	assign wr_ack    = ack_pipe[WRITE_LATENCY-1];

	always_ff @(posedge clk_sys) begin
		if (reset)
			ack_pipe <= '0;
		else
			ack_pipe <= {ack_pipe[WRITE_LATENCY-2:0], wr_req};
	end

	always_ff @(posedge clk_sys) begin
		if (wr_strobe)
			mem[wr_addr] <= wr_data;
	end

	// ========================================================================
	// Read side
	// ========================================================================
	// Skip the header, then mirror into the written image
	assign rd_phys = has_header ? (rd_addr + rom_addr_t'(HEADER_BYTES)) & header_mask
	                            : rd_addr & cart_mask;

	always_ff @(posedge clk_sys) begin
		if (reset)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd;
	end

	always_ff @(posedge clk_sys) begin
		if (rd)
			rd_data <= mem[rd_phys];
	end

endmodule

/* src/cheat_code_collector.sv */
// Cheat record assembly from downloaded bytes into flags, address, compare and replace
`timescale 1ns/1ps

module cheat_code_collector (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  code_active,
	input  logic                  dl_wr,
	input  cart_pkg::rom_addr_t   dl_addr,
	input  logic [7:0]            dl_data,
	output cheat_pkg::code_field_t code_flags,
	output cheat_pkg::code_field_t code_address,
	output cheat_pkg::code_field_t code_compare,
	output cheat_pkg::code_field_t code_replace,
	output logic                  code_valid
);
	import cheat_pkg::*;

	logic [CODE_BYTE_W-1:0] byte_num;
	int                     field_num;
	int                     byte_pos;
	logic                   code_wr;

	assign code_wr   = code_active & dl_wr;
	assign byte_num  = dl_addr[CODE_BYTE_W-1:0];   // Position inside the record
	assign field_num = int'(byte_num) / FIELD_BYTES;
	assign byte_pos  = int'(byte_num) % FIELD_BYTES;

	// ========================================================================
	// Field assembly, little endian within each field
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (field_num)
				FIELD_FLAGS:   code_flags[8*byte_pos +: 8]   <= dl_data;
				FIELD_ADDR:    code_address[8*byte_pos +: 8] <= dl_data;
				FIELD_COMPARE: code_compare[8*byte_pos +: 8] <= dl_data;
				FIELD_REPLACE: code_replace[8*byte_pos +: 8] <= dl_data;
				default: ;
			endcase
		end
	end

	// Last byte of the record completes the code
	always_ff @(posedge clk_sys) begin
		if (reset)
			code_valid <= 1'b0;
		else
			code_valid <= code_wr && (int'(byte_num) == CODE_BYTES - 1);
	end

endmodule

/* src/cart_core.sv */
// Cartridge side top level: download index split, loader, ROM store, cheats, enables
`timescale 1ns/1ps

module cart_core (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active,
	input  logic [7:0]             dl_index,
	input  logic                   dl_wr,
	input  cart_pkg::rom_addr_t    dl_addr,
	input  logic [7:0]             dl_data,
	output logic                   dl_wait,
	input  logic                   rd,
	input  cart_pkg::rom_addr_t    rd_addr,
	output logic [7:0]             rd_data,
	output logic                   rd_valid,
	output cheat_pkg::code_field_t code_flags,
	output cheat_pkg::code_field_t code_address,
	output cheat_pkg::code_field_t code_compare,
	output cheat_pkg::code_field_t code_replace,
	output logic                   code_valid,
	output logic                   game_gear,
	output logic                   ce_cpu,
	output logic                   ce_vdp,
	output logic                   ce_pix,
	output logic                   ce_sp
);
	import cart_pkg::*;

	logic       code_index;
	logic       cart_active;
	logic       code_active;
	rom_addr_t  wr_addr;
	logic [7:0] wr_data;
	logic       wr_req;
	logic       wr_ack;
	rom_addr_t  cart_mask;
	rom_addr_t  header_mask;
	logic       has_header;

	// ========================================================================
	// Download split, all ones index carries cheat records
	// ========================================================================
	assign code_index  = dl_index == CODE_INDEX;
	assign cart_active = dl_active & ~code_index;
	assign code_active = dl_active & code_index;

	clock_enable_gen i_clock_enable_gen (
		.clk_sys, .reset, .ce_cpu, .ce_vdp, .ce_pix, .ce_sp
	);

	rom_loader i_rom_loader (
		.clk_sys, .reset, .cart_active, .dl_wr, .dl_index, .dl_data, .dl_wait,
		.wr_addr, .wr_data, .wr_req, .wr_ack,
		.cart_mask, .header_mask, .has_header, .game_gear
	);

	rom_store i_rom_store (
		.clk_sys, .reset, .wr_addr, .wr_data, .wr_req, .wr_ack,
		.cart_mask, .header_mask, .has_header,
		.rd, .rd_addr, .rd_data, .rd_valid
	);

	cheat_code_collector i_cheat_code_collector (
		.clk_sys, .reset, .code_active, .dl_wr, .dl_addr, .dl_data,
		.code_flags, .code_address, .code_compare, .code_replace, .code_valid
	);

endmodule

/* bench/cart_core_sva.sv */
// Bound assertions on clock enables, download wait and cheat code pulse
`timescale 1ns/1ps

module cart_core_sva (
	input logic clk_sys,
	input logic reset,
	input logic ce_cpu,
	input logic ce_vdp,
	input logic cart_active,
	input logic dl_wr,
	input logic dl_wait,
	input logic code_valid
);
	import cart_pkg::*;

	// CPU enable always lands on a VDP slot
	assert property (@(posedge clk_sys) disable iff (reset) ce_cpu |-> ce_vdp)
		else $error("ce_cpu asserted without ce_vdp");

	assert property (@(posedge clk_sys) disable iff (reset)
		dl_wr && cart_active && !dl_wait |=> dl_wait)
		else $error("dl_wait did not rise after an accepted write");

	// Store acknowledge, then one cycle to release
	assert property (@(posedge clk_sys) disable iff (reset)
		$rose(dl_wait) |-> ##(WRITE_LATENCY + 1) !dl_wait)
		else $error("dl_wait not released after the write acknowledge");

	assert property (@(posedge clk_sys) disable iff (reset) code_valid |=> !code_valid)
		else $error("code_valid held longer than one cycle");

endmodule

bind cart_core cart_core_sva i_cart_core_sva (
	.clk_sys, .reset, .ce_cpu, .ce_vdp, .cart_active, .dl_wr, .dl_wait, .code_valid
);

/* bench/cart_core_tb.sv */
// Testbench for cart_core: clock, reset, downloads, masked reads, cheat record, reference model
`timescale 1ns/1ps

module cart_core_tb;
	import cart_pkg::*;
	import cheat_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int WAIT_LIMIT   = 20;   // Cycles per handshake wait

	logic        clk_sys;
	logic        reset;
	logic        dl_active;
	logic [7:0]  dl_index;
	logic        dl_wr;
	rom_addr_t   dl_addr;
	logic [7:0]  dl_data;
	logic        dl_wait;
	logic        rd;
	rom_addr_t   rd_addr;
	logic [7:0]  rd_data;
	logic        rd_valid;
	code_field_t code_flags;
	code_field_t code_address;
	code_field_t code_compare;
	code_field_t code_replace;
	logic        code_valid;
	logic        game_gear;
	logic        ce_cpu;
	logic        ce_vdp;
	logic        ce_pix;
	logic        ce_sp;

	// Reference model state
	logic [7:0]  image [ROM_DEPTH];
	logic [7:0]  cheat_bytes [CODE_BYTES];
	rom_addr_t   ref_cart_mask;
	rom_addr_t   ref_header_mask;
	logic        ref_has_header;
	logic [31:0] rng_state;
	int          cyc = 0;
	int          code_pulses = 0;
	logic [7:0]  exp_data [$];          // Expected read bytes in issue order
	int          exp_cycle [$];         // Cycle each read must return in

	cart_core i_cart_core (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys)
		cyc <= cyc + 1;

	// ========================================================================
	// Helpers
	// ========================================================================
	function automatic logic [31:0] xorshift_next();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			report_failure($sformatf("Error at %0t: %s is %0h, expected %0h",
				$time, what, got, exp));
	endtask

	// Expected byte after header skip and mirroring
	function automatic logic [7:0] expected_byte(input rom_addr_t addr);
		int phys;
		if (ref_has_header)
			phys = (int'(addr) + HEADER_BYTES) & int'(ref_header_mask);
		else
			phys = int'(addr) & int'(ref_cart_mask);
		return image[rom_addr_t'(phys)];
	endfunction

	// Little endian field from one byte group of the record
	function automatic code_field_t assemble_field(input int field);
		code_field_t f;
		int          k;
		f = '0;
		for (k = FIELD_BYTES - 1; k >= 0; k--)
			f = {f[CODE_FIELD_W-9:0], cheat_bytes[CODE_BYTE_W'(field * FIELD_BYTES + k)]};
		return f;
	endfunction

	task automatic wait_dl_wait(input logic level, input int limit);
		int n;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (dl_wait !== level && n < limit);
		if (dl_wait !== level)
			report_failure($sformatf("Timeout: dl_wait did not go to %0d within %0d cycles",
				level, limit));
	endtask

	task automatic wait_code_valid(input int limit);
		int n;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (code_valid !== 1'b1 && n < limit);
		if (code_valid !== 1'b1)
			report_failure("Timeout: code_valid did not pulse right after the last cheat byte");
	endtask

	// ========================================================================
	// Stimulus tasks
	// ========================================================================
	task automatic check_enables();
		logic [3:0] seen [2*CE_PERIOD];
		int         n_cpu;
		int         n_vdp;
		int         n_pix;
		int         n_sp;
		int         i;
		n_cpu = 0;
		n_vdp = 0;
		n_pix = 0;
		n_sp  = 0;
		@(negedge clk_sys);   // Enables here still hold their reset values
		for (i = 0; i < 2 * CE_PERIOD; i++) begin
			@(negedge clk_sys);
			seen[6'(i)] = {ce_cpu, ce_vdp, ce_pix, ce_sp};
			if (ce_cpu && !ce_vdp)
				report_failure("ce_cpu pulsed without ce_vdp");
			if (i < CE_PERIOD) begin   // One full window
				n_cpu += int'(ce_cpu);
				n_vdp += int'(ce_vdp);
				n_pix += int'(ce_pix);
				n_sp  += int'(ce_sp);
			end
		end
		check_value("ce_cpu pulses", n_cpu, 2);
		check_value("ce_vdp pulses", n_vdp, 6);
		check_value("ce_pix pulses", n_pix, 3);
		check_value("ce_sp pulses", n_sp, 15);
		for (i = 0; i < CE_PERIOD; i++)
			check_value("enable repeat", 32'(seen[6'(i + CE_PERIOD)]), 32'(seen[6'(i)]));
	endtask

	task automatic download_cart(input logic [7:0] index, input int nbytes);
		rom_addr_t addr;
		int        i;
		@(posedge clk_sys);
		#2;
		dl_active       = 1'b1;
		dl_index        = index;
		ref_cart_mask   = '0;
		ref_header_mask = '0;
		for (i = 0; i < nbytes; i++) begin
			addr        = rom_addr_t'(i);
			image[addr] = 8'(xorshift_next());
			@(posedge clk_sys);
			#2;
			dl_wr   = 1'b1;
			dl_addr = addr;
			dl_data = image[addr];
			@(posedge clk_sys);
			#2;
			dl_wr = 1'b0;
			wait_dl_wait(1'b1, 1);
			wait_dl_wait(1'b0, WAIT_LIMIT);
			// Masks restart at the image start and at the header end
			ref_cart_mask   = (i == 0) ? '0 : ref_cart_mask | addr;
			ref_header_mask = (i == HEADER_BYTES) ? '0 :
				ref_header_mask | rom_addr_t'(i - HEADER_BYTES);
		end
		ref_has_header = ((nbytes / HEADER_BYTES) % 2) == 1;
		@(posedge clk_sys);
		#2;
		dl_active = 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic issue_read(input rom_addr_t addr);
		@(posedge clk_sys);
		#2;
		rd      = 1'b1;
		rd_addr = addr;
		exp_data.push_back(expected_byte(addr));
		exp_cycle.push_back(cyc + 1);
	endtask

	task automatic pause_read();
		@(posedge clk_sys);
		#2;
		rd = 1'b0;
	endtask

	task automatic run_reads(input int count);
		int n;
		int i;
		issue_read(12'h000);   // Store ends and mirror edges, back to back
		issue_read(12'h7ff);
		issue_read(12'h800);
		issue_read(12'hfff);
		for (i = 0; i < count; i++) begin
			issue_read(rom_addr_t'(xorshift_next()));
			if (rng_state[20])
				pause_read();
		end
		pause_read();
		n = 0;
		while (exp_data.size() != 0 && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (exp_data.size() != 0)
			report_failure("Timeout: not every read returned its data");
	endtask

	task automatic download_cheat();
		int i;
		@(posedge clk_sys);
		#2;
		dl_active = 1'b1;
		dl_index  = CODE_INDEX;
		for (i = 0; i < CODE_BYTES; i++) begin
			cheat_bytes[CODE_BYTE_W'(i)] = 8'(xorshift_next());
			@(posedge clk_sys);
			#2;
			dl_wr   = 1'b1;
			dl_addr = rom_addr_t'(2 * CODE_BYTES + i);   // Third record slot
			dl_data = cheat_bytes[CODE_BYTE_W'(i)];
		end
		@(posedge clk_sys);
		#2;
		dl_wr = 1'b0;
		wait_code_valid(1);
		check_value("code_flags", code_flags, assemble_field(FIELD_FLAGS));
		check_value("code_address", code_address, assemble_field(FIELD_ADDR));
		check_value("code_compare", code_compare, assemble_field(FIELD_COMPARE));
		check_value("code_replace", code_replace, assemble_field(FIELD_REPLACE));
		@(posedge clk_sys);
		#2;
		dl_active = 1'b0;
		repeat (4) @(posedge clk_sys);
		check_value("code_valid pulses", code_pulses, 1);
		check_value("dl_wait during cheat download", 32'(dl_wait), 0);
	endtask

	// ========================================================================
	// Read data comparison and code pulse count
	// ========================================================================
	always @(negedge clk_sys) begin
		if (rd_valid === 1'b1) begin
			if (exp_data.size() == 0) begin
				report_failure("Read data returned with no read outstanding");
			end else begin
				check_value("read return cycle", cyc, exp_cycle.pop_front());
				check_value("read data", 32'(rd_data), 32'(exp_data.pop_front()));
			end
		end
		if (code_valid === 1'b1)
			code_pulses = code_pulses + 1;
	end

	initial begin
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_index  = '0;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		rd        = 1'b0;
		rd_addr   = '0;
		rng_state = 32'h63a4;

		repeat (RESET_CYCLES - 1) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("outputs in reset",
			32'({dl_wait, code_valid, rd_valid, ce_cpu, ce_vdp, ce_pix, ce_sp}), 0);
		@(posedge clk_sys);
		#2;
		reset = 1'b0;

		check_enables();

		download_cart(8'd2, 2048);   // Plain Game Gear image, mirrored above 2 KiB
		check_value("game_gear after index 2", 32'(game_gear), 1);
		run_reads(300);

		download_cart(8'd1, 1536);   // Copier header in front of 1 KiB
		check_value("game_gear after index 1", 32'(game_gear), 0);
		run_reads(300);

		download_cheat();

		repeat (4) @(posedge clk_sys);
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* sources.f */
src/cart_pkg.sv
src/cheat_pkg.sv
src/clock_enable_gen.sv
src/rom_loader.sv
src/rom_store.sv
src/cheat_code_collector.sv
src/cart_core.sv
bench/cart_core_sva.sv
bench/cart_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run cart_core_tb with Verilator, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
sim_out=""
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module cart_core_tb -f sources.f -o cart_core_sim &&
	sim_out=$(./obj_dir/cart_core_sim)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "^Result: PASSED$" && echo "Simulation passed" || {
	echo "Simulation failed"
	exit 1
}
